// File: verilog/con_defs.svh
`ifndef CON_DEFS_SVH
`define CON_DEFS_SVH

// Microword field widths
`define CON_COND_W 6
`define CON_MAGIC_W 9

// Console bus
`define CON_WB_DW 8
`define CON_WB_AW 2

// Run and start chain length
`define CON_SYNC_STAGES 3

// COND values with a strobe of their own
`define CON_COND_LOAD_IR 6'o14
`define CON_COND_SPEC_INSTR 6'o15
`define CON_COND_EBOX_STATE 6'o21

`endif

// File: verilog/conUcodePkg.sv
`default_nettype none
`include "con_defs.svh"

package conUcodePkg;

  // COND is read as two octal digits
  typedef logic [`CON_COND_W/2-1:0] condSel;

  typedef enum logic [`CON_COND_W/2-1:0] {
    grpCond00, grpCond10, grpCond20, grpCond30,
    grpSkip40, grpSkip50, grpSkip60, grpSkip70
  } condGroup;

  typedef struct packed {
    condGroup group;
    condSel   sel;
  } condField;

  // Bit i of the word is MAGIC bit mi
  typedef struct packed {
    logic m8;
    logic eboxHalted;
    logic m6;
    logic intDisable;
    logic pxct;
    logic m3;
    logic pcPlus1Inh;
    logic kernelCycle;
    logic m0;
  } specFlagsView;

  typedef struct packed {
    logic holdBit;
    logic setBit;
  } statePair;

  // pair[k] is set m(2k+1) and hold m(2k+2)
  typedef struct packed {
    statePair [3:0] pair;
    logic           m0;
  } stateCtlView;

  typedef union packed {
    specFlagsView specFlags;
    stateCtlView  stateCtl;
  } magicWord;

endpackage

`default_nettype wire

// File: verilog/conConsolePkg.sv
`default_nettype none
`include "con_defs.svh"

package conConsolePkg;

  // Console register map
  typedef enum logic [`CON_WB_AW-1:0] {
    readSel = 2'd0,
    conoPag = 2'd1,
    conoPar = 2'd2,
    diagCtl = 2'd3
  } consoleReg;

  // Diagnostic control functions, other codes do nothing
  typedef enum logic [2:0] {
    clrRun      = 3'd0,
    setRun      = 3'd1,
    continueRun = 3'd2
  } diagFunc;

  typedef enum logic [2:0] {
    rowPag      = 3'd0,
    rowPar      = 3'd1,
    rowFlags    = 3'd2,
    rowUState   = 3'd3,
    rowRunStart = 3'd4
  } readbackRow;

endpackage

`default_nettype wire

// File: verilog/conIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded COND strobes and skip enables
interface condIf import conUcodePkg::*; ();
  logic   condSpecInstr;
  logic   condLoadIr;
  logic   condEboxState;
  logic   skipEn6x;
  logic   skipEn7x;
  condSel sel;

  modport src (
    output condSpecInstr,
    output condLoadIr,
    output condEboxState,
    output skipEn6x,
    output skipEn7x,
    output sel
  );

  modport skipSink (input skipEn6x, input skipEn7x, input sel);

  modport stateSink (input condSpecInstr, input condEboxState);
endinterface

// Diagnostic function path and run state return
interface consoleIf import conConsolePkg::*; ();
  logic    diagStrobe;
  diagFunc diagCode;
  logic    runState;
  logic    startState;

  modport src (
    output diagStrobe,
    output diagCode,
    input  runState,
    input  startState
  );

  modport runSink (
    input  diagStrobe,
    input  diagCode,
    output runState,
    output startState
  );
endinterface

`default_nettype wire

// File: verilog/condDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "con_defs.svh"

module condDecoder import conUcodePkg::*; (
  input  condField cond,
  output logic     loadIr,
  condIf.src       cIf
);

  // Strobes from the 10-17 and 20-27 groups
  assign cIf.condLoadIr    = (cond == `CON_COND_LOAD_IR);
  assign cIf.condSpecInstr = (cond == `CON_COND_SPEC_INSTR);
  assign cIf.condEboxState = (cond == `CON_COND_EBOX_STATE);

  // Skip groups
  assign cIf.skipEn6x = (cond.group == grpSkip60);
  assign cIf.skipEn7x = (cond.group == grpSkip70);

  // Low digit picks the condition inside a group
  assign cIf.sel = cond.sel;

  // Only the microcode path to IR load remains
  assign loadIr = cIf.condLoadIr;

endmodule

`default_nettype wire

// File: verilog/dispatchSkip.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchSkip import conUcodePkg::*; (
  input  logic    conCLK,
  input  logic    CLK,
  condIf.skipSink cIf,
  input  logic    vmaFetch,
  input  logic    user,
  input  logic    userIot,
  input  logic    public,
  input  logic    rdPseWr,
  input  logic    piCycle,
  input  logic    piXfer,
  input  logic    ioLegalIr,
  input  logic    vmaSection0,
  input  logic    acRef,
  input  logic    piReady,
  input  logic    mtrIntReq,
  input  logic    intDisable,
  input  logic    pxct,
  input  logic    runState,
  input  logic    startState,
  output logic    skip,
  output logic    kernelMode
);

  logic       piReadyReg;
  logic       mtrIntReqReg;
  logic       intReq;
  logic       ioLegal;
  logic [7:0] cond6x;
  logic [7:0] cond7x;
  condSel     sel;

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      piReadyReg   <= 1'b0;
      mtrIntReqReg <= 1'b0;
    end else begin
      piReadyReg   <= piReady;
      mtrIntReqReg <= mtrIntReq;
    end
  end

  assign intReq     = (piReadyReg | mtrIntReqReg) & ~intDisable;
  assign kernelMode = ~user & ~public;
  assign ioLegal    = ioLegalIr | kernelMode | (user & userIot);

  // Entry i is skip condition 6i, grant line is gone
  assign cond6x = {1'b0, ~piXfer, piCycle, rdPseWr,
                   public, user, kernelMode, vmaFetch};

  // Entry i is skip condition 7i
  assign cond7x = {~mtrIntReqReg, acRef, vmaSection0, pxct,
                   ioLegal, runState, ~startState, intReq};

  assign sel  = cIf.sel;
  assign skip = (cIf.skipEn6x & cond6x[sel]) | (cIf.skipEn7x & cond7x[sel]);

endmodule

`default_nettype wire

// File: verilog/runControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "con_defs.svh"

module runControl import conConsolePkg::*; (
  input  logic      conCLK,
  input  logic      CLK,
  consoleIf.runSink dIf,
  output logic      run,
  output logic      start
);

  localparam int stages = `CON_SYNC_STAGES;

  logic [stages-1:0] runChain;
  logic [stages-1:0] startChain;
  logic              runNext;
  logic              startLaunch;

  // First run stage holds the state, set and clear act on it
  always_comb begin
    runNext = runChain[0];
    if (dIf.diagStrobe) begin
      case (dIf.diagCode)
        setRun:  runNext = 1'b1;
        clrRun:  runNext = 1'b0;
        default: runNext = runChain[0];
      endcase
    end
  end

  assign startLaunch = dIf.diagStrobe && (dIf.diagCode == continueRun);

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runChain   <= '0;
      startChain <= '0;
    end else begin
      runChain   <= {runChain[stages-2:0], runNext};
      startChain <= {startChain[stages-2:0], startLaunch};
    end
  end

  assign run            = runChain[stages-1];
  assign start          = startChain[stages-1];
  assign dIf.runState   = run;
  assign dIf.startState = start;

endmodule

`default_nettype wire

// File: verilog/specInstrState.sv
`timescale 1ns/1ps
`default_nettype none

module specInstrState import conUcodePkg::*; (
  input  logic       conCLK,
  input  logic       CLK,
  condIf.stateSink   cIf,
  input  magicWord   magic,
  output logic       kernelCycle,
  output logic       pxct,
  output logic       intDisable,
  output logic       eboxHalted,
  output logic       pcPlus1Inh,
  output logic [3:0] ucodeState
);

  logic [3:0] nextState;

  // Special-instruction flags
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      kernelCycle <= 1'b0;
      pxct        <= 1'b0;
      intDisable  <= 1'b0;
      eboxHalted  <= 1'b0;
      pcPlus1Inh  <= 1'b0;
    end else if (cIf.condSpecInstr) begin
      kernelCycle <= magic.specFlags.kernelCycle;
      pxct        <= magic.specFlags.pxct;
      intDisable  <= magic.specFlags.intDisable;
      eboxHalted  <= magic.specFlags.eboxHalted;
      pcPlus1Inh  <= magic.specFlags.pcPlus1Inh;
    end
  end

  // Set wins, hold keeps, neither clears
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      nextState[k] = magic.stateCtl.pair[k].setBit |
                     (magic.stateCtl.pair[k].holdBit & ucodeState[k]);
    end
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      ucodeState <= '0;
    end else if (cIf.condEboxState) begin
      ucodeState <= nextState;
    end
  end

endmodule

`default_nettype wire

// File: verilog/consoleRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "con_defs.svh"

module consoleRegs import conConsolePkg::*; (
  input  logic                  conCLK,
  input  logic                  CLK,
  input  logic                  wbCyc,
  input  logic                  wbStb,
  input  logic                  wbWe,
  input  logic [`CON_WB_AW-1:0] wbAdr,
  input  logic [`CON_WB_DW-1:0] wbDatW,
  output logic [`CON_WB_DW-1:0] wbDatR,
  output logic                  wbAck,
  consoleIf.src                 dIf,
  input  logic                  kernelCycle,
  input  logic                  pcPlus1Inh,
  input  logic                  pxct,
  input  logic                  intDisable,
  input  logic                  eboxHalted,
  input  logic [3:0]            ucodeState,
  output logic                  cacheLookEn,
  output logic                  cacheLoadEn,
  output logic                  klPagingEn,
  output logic                  trapEn
);

  logic       request;
  logic       writeHit;
  consoleReg  target;
  readbackRow rowSel;
  logic       wrEvenParAdr;
  logic       wrEvenParData;
  logic       wrEvenParDir;

  // A held strobe starts the next cycle after the ack cycle
  assign request  = wbCyc & wbStb & ~wbAck;
  assign writeHit = request & wbWe;
  assign target   = consoleReg'(wbAdr);

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= request;
    end
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      rowSel         <= rowPag;
      cacheLookEn    <= 1'b0;
      cacheLoadEn    <= 1'b0;
      klPagingEn     <= 1'b0;
      trapEn         <= 1'b0;
      wrEvenParAdr   <= 1'b0;
      wrEvenParData  <= 1'b0;
      wrEvenParDir   <= 1'b0;
      dIf.diagStrobe <= 1'b0;
      dIf.diagCode   <= clrRun;
    end else begin
      dIf.diagStrobe <= 1'b0;
      if (writeHit) begin
        case (target)
          readSel: rowSel <= readbackRow'(wbDatW[2:0]);
          conoPag: begin
            cacheLookEn <= wbDatW[0];
            cacheLoadEn <= wbDatW[1];
            klPagingEn  <= wbDatW[2];
            trapEn      <= wbDatW[3];
          end
          conoPar: begin
            wrEvenParAdr  <= wbDatW[0];
            wrEvenParData <= wbDatW[1];
            wrEvenParDir  <= wbDatW[2];
          end
          diagCtl: begin
            dIf.diagStrobe <= 1'b1;
            dIf.diagCode   <= diagFunc'(wbDatW[2:0]);
          end
        endcase
      end
    end
  end

  // Diagnostic readback, rows 5 to 7 read as zero
  always_comb begin
    wbDatR = '0;
    case (rowSel)
      rowPag:      wbDatR[3:0] = {trapEn, klPagingEn, cacheLoadEn, cacheLookEn};
      rowPar:      wbDatR[2:0] = {wrEvenParDir, wrEvenParData, wrEvenParAdr};
      rowFlags:    wbDatR[4:0] = {eboxHalted, intDisable, pxct, pcPlus1Inh, kernelCycle};
      rowUState:   wbDatR[3:0] = ucodeState;
      rowRunStart: wbDatR[1:0] = {dIf.startState, dIf.runState};
      default:     wbDatR = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/conTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "con_defs.svh"

module conTop (
  input  logic                    conCLK,
  input  logic                    CLK,
  input  logic [`CON_COND_W-1:0]  cond,
  input  logic [`CON_MAGIC_W-1:0] magic,
  input  logic                    vmaFetch,
  input  logic                    user,
  input  logic                    userIot,
  input  logic                    public,
  input  logic                    rdPseWr,
  input  logic                    piCycle,
  input  logic                    piXfer,
  input  logic                    ioLegalIr,
  input  logic                    vmaSection0,
  input  logic                    acRef,
  input  logic                    piReady,
  input  logic                    mtrIntReq,
  input  logic                    wbCyc,
  input  logic                    wbStb,
  input  logic                    wbWe,
  input  logic [`CON_WB_AW-1:0]   wbAdr,
  input  logic [`CON_WB_DW-1:0]   wbDatW,
  output logic [`CON_WB_DW-1:0]   wbDatR,
  output logic                    wbAck,
  output logic                    skip,
  output logic                    loadIr,
  output logic                    run,
  output logic                    start,
  output logic                    kernelMode,
  output logic                    pxct,
  output logic                    intDisable,
  output logic                    eboxHalted,
  output logic                    pcPlus1Inh,
  output logic [3:0]              ucodeState,
  output logic                    cacheLookEn,
  output logic                    cacheLoadEn,
  output logic                    klPagingEn,
  output logic                    trapEn
);

  logic kernelCycle;

  condIf    i_condIf ();
  consoleIf i_consoleIf ();

  condDecoder i_condDecoder (
    .cond   (cond),
    .loadIr (loadIr),
    .cIf    (i_condIf.src)
  );

  dispatchSkip i_dispatchSkip (
    .conCLK      (conCLK),
    .CLK         (CLK),
    .cIf         (i_condIf.skipSink),
    .vmaFetch    (vmaFetch),
    .user        (user),
    .userIot     (userIot),
    .public      (public),
    .rdPseWr     (rdPseWr),
    .piCycle     (piCycle),
    .piXfer      (piXfer),
    .ioLegalIr   (ioLegalIr),
    .vmaSection0 (vmaSection0),
    .acRef       (acRef),
    .piReady     (piReady),
    .mtrIntReq   (mtrIntReq),
    .intDisable  (intDisable),
    .pxct        (pxct),
    .runState    (run),
    .startState  (start),
    .skip        (skip),
    .kernelMode  (kernelMode)
  );

  runControl i_runControl (
    .conCLK (conCLK),
    .CLK    (CLK),
    .dIf    (i_consoleIf.runSink),
    .run    (run),
    .start  (start)
  );

  specInstrState i_specInstrState (
    .conCLK      (conCLK),
    .CLK         (CLK),
    .cIf         (i_condIf.stateSink),
    .magic       (magic),
    .kernelCycle (kernelCycle),
    .pxct        (pxct),
    .intDisable  (intDisable),
    .eboxHalted  (eboxHalted),
    .pcPlus1Inh  (pcPlus1Inh),
    .ucodeState  (ucodeState)
  );

  consoleRegs i_consoleRegs (
    .conCLK      (conCLK),
    .CLK         (CLK),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbDatW      (wbDatW),
    .wbDatR      (wbDatR),
    .wbAck       (wbAck),
    .dIf         (i_consoleIf.src),
    .kernelCycle (kernelCycle),
    .pcPlus1Inh  (pcPlus1Inh),
    .pxct        (pxct),
    .intDisable  (intDisable),
    .eboxHalted  (eboxHalted),
    .ucodeState  (ucodeState),
    .cacheLookEn (cacheLookEn),
    .cacheLoadEn (cacheLoadEn),
    .klPagingEn  (klPagingEn),
    .trapEn      (trapEn)
  );

endmodule

`default_nettype wire

// File: testbench/con_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "con_defs.svh"

module conProperties (
  input logic                   conCLK,
  input logic                   CLK,
  input logic [`CON_COND_W-1:0] cond,
  input logic                   wbCyc,
  input logic                   wbStb,
  input logic                   wbAck,
  input logic                   start,
  input logic                   skip
);

  // Ack needs a request on the previous cycle
  ackAfterRequest: assert property (
    @(posedge conCLK) disable iff (CLK) wbAck |-> $past(wbCyc && wbStb)
  ) else $error("wbAck without a request on the previous cycle");

  ackOneCycle: assert property (
    @(posedge conCLK) disable iff (CLK) wbAck |=> !wbAck
  ) else $error("wbAck held for more than one cycle");

  startPulse: assert property (
    @(posedge conCLK) disable iff (CLK) start |=> !start
  ) else $error("start held for more than one cycle");

  // Only groups 60 and 70 can skip
  skipGroups: assert property (
    @(posedge conCLK) disable iff (CLK) (cond[5:4] != 2'b11) |-> !skip
  ) else $error("skip high outside the 60-77 COND range");

endmodule

`default_nettype wire

// File: testbench/conTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "con_defs.svh"

module conTb import conConsolePkg::*; ();

  localparam int periodNs    = 10;
  localparam int resetCycles = 10;
  localparam int consIters   = 8;
  localparam int flagIters   = 12;
  localparam int stateIters  = 12;
  localparam int skipIters   = 64;
  // Bus transfers plus COND cycles
  localparam int numOps  = consIters * 6 + 8 + flagIters * 2 + 2 + stateIters +
                           skipIters + 1;
  localparam int watchNs = (resetCycles + numOps * 20) * periodNs;

  logic                    conCLK;
  logic                    CLK;
  logic [`CON_COND_W-1:0]  cond;
  logic [`CON_MAGIC_W-1:0] magic;
  logic                    vmaFetch, user, userIot, public, rdPseWr;
  logic                    piCycle, piXfer, ioLegalIr, vmaSection0, acRef;
  logic                    piReady, mtrIntReq;
  logic                    wbCyc, wbStb, wbWe, wbAck;
  logic [`CON_WB_AW-1:0]   wbAdr;
  logic [`CON_WB_DW-1:0]   wbDatW;
  logic [`CON_WB_DW-1:0]   wbDatR;
  logic                    skip, loadIr, run, start, kernelMode;
  logic                    pxct, intDisable, eboxHalted, pcPlus1Inh;
  logic [3:0]              ucodeState;
  logic                    cacheLookEn, cacheLoadEn, klPagingEn, trapEn;

  logic [31:0] seed;
  string       nameQ[$];
  logic [8:0]  expQ[$];
  logic [8:0]  actQ[$];
  event        checkEv;
  int          nChecks = 0;
  int          nErrors = 0;

  conTop i_conTop (.*);

  bind conTop conProperties i_conProperties (
    .conCLK (conCLK),
    .CLK    (CLK),
    .cond   (cond),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck),
    .start  (start),
    .skip   (skip)
  );

  initial conCLK = 1'b0;
  always #(periodNs / 2) conCLK = ~conCLK;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic nextRand(output logic [31:0] value);
    seed  = lcgNext(seed);
    value = seed ^ (seed >> 15);
  endtask

  // Row 2 order, m7 m5 m4 m2 m1
  function automatic logic [4:0] refFlags(input logic [8:0] m);
    return {m[7], m[5], m[4], m[2], m[1]};
  endfunction

  function automatic logic [3:0] refState(input logic [3:0] cur, input logic [8:0] m);
    logic [3:0] nxt;
    for (int k = 0; k < 4; k++) begin
      nxt[k] = m[2*k+1] | (m[2*k+2] & cur[k]);
    end
    return nxt;
  endfunction

  // d is vmaFetch user userIot public rdPseWr piCycle piXfer ioLegalIr vmaSection0 acRef
  function automatic logic refSkip(input logic [5:0] c, input logic [9:0] d,
                                   input logic pi, input logic mtr,
                                   input logic [4:0] flags, input logic runNow,
                                   input logic startNow);
    logic       kernel;
    logic       ioLegal;
    logic       intReq;
    logic [7:0] g6;
    logic [7:0] g7;
    kernel  = ~d[8] & ~d[6];
    ioLegal = d[2] | kernel | (d[8] & d[7]);
    intReq  = (pi | mtr) & ~flags[3];
    g6 = {1'b0, ~d[3], d[4], d[5], d[6], d[8], kernel, d[9]};
    g7 = {~mtr, d[0], d[1], flags[2], ioLegal, runNow, ~startNow, intReq};
    case (c[5:3])
      3'o6:    return g6[c[2:0]];
      3'o7:    return g7[c[2:0]];
      default: return 1'b0;
    endcase
  endfunction

  // Avoid COND values that load flags or state
  function automatic logic [5:0] quietCond(input logic [5:0] c);
    return (c == `CON_COND_SPEC_INSTR || c == `CON_COND_EBOX_STATE) ? 6'o00 : c;
  endfunction

  task automatic postCheck(input string name, input logic [8:0] expVal,
                           input logic [8:0] actVal);
    nameQ.push_back(name);
    expQ.push_back(expVal);
    actQ.push_back(actVal);
    -> checkEv;
  endtask

  always @(checkEv) begin : compare
    string      name;
    logic [8:0] expVal;
    logic [8:0] actVal;
    while (nameQ.size() > 0) begin
      name   = nameQ.pop_front();
      expVal = expQ.pop_front();
      actVal = actQ.pop_front();
      nChecks++;
      if (actVal !== expVal) begin
        nErrors++;
        $display("ERR %s expected %h actual %h", name, expVal, actVal);
      end
    end
  end

  // Starts 1 ns after a rising edge, returns 1 ns after the edge following the ack
  task automatic wbXfer(input logic we, input logic [1:0] adr, input logic [7:0] dat,
                        output logic [7:0] rdat);
    int waitCnt;
    waitCnt = 0;
    wbCyc   = 1'b1;
    wbStb   = 1'b1;
    wbWe    = we;
    wbAdr   = adr;
    wbDatW  = dat;
    @(negedge conCLK);
    while (!wbAck && waitCnt < 8) begin
      waitCnt++;
      @(negedge conCLK);
    end
    if (!wbAck) begin
      nErrors++;
      $display("Wishbone cycle to address %0d got no acknowledge", adr);
    end else begin
      // Ack on the first edge is seen one falling edge later
      postCheck("wbAckLatency", 9'd1, 9'(waitCnt));
    end
    rdat = wbDatR;
    @(posedge conCLK);
    #1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbWrite(input logic [1:0] adr, input logic [7:0] dat);
    logic [7:0] ignored;
    wbXfer(1'b1, adr, dat, ignored);
  endtask

  task automatic wbRead(input logic [1:0] adr, output logic [7:0] dat);
    wbXfer(1'b0, adr, 8'h00, dat);
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [7:0]  rd;
    logic [5:0]  c;
    logic [4:0]  flags;
    logic [3:0]  ustate;
    logic        prevPi;
    logic        prevMtr;
    logic        runNow;
    seed   = 32'h9e88;
    CLK    = 1'b1;
    cond   = '0;
    magic  = '0;
    {vmaFetch, user, userIot, public, rdPseWr} = '0;
    {piCycle, piXfer, ioLegalIr, vmaSection0, acRef} = '0;
    piReady   = 1'b0;
    mtrIntReq = 1'b0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    flags  = '0;
    ustate = '0;
    runNow = 1'b0;
    repeat (resetCycles) @(posedge conCLK);
    #1;
    CLK = 1'b0;
    @(posedge conCLK);
    #1;

    // Paging and parity registers with readback
    for (int i = 0; i < consIters; i++) begin
      nextRand(r);
      wbWrite(conoPag, r[7:0]);
      wbWrite(conoPar, r[15:8]);
      postCheck("pagingOut", r[3:0], {trapEn, klPagingEn, cacheLoadEn, cacheLookEn});
      wbWrite(readSel, {5'b0, rowPag});
      wbRead(readSel, rd);
      postCheck("row0", r[3:0], rd);
      wbWrite(readSel, {5'b0, rowPar});
      wbRead(readSel, rd);
      postCheck("row1", r[10:8], rd);
    end

    // Run and start chains, 3 cycles after the ack edge
    wbWrite(diagCtl, {5'b0, setRun});
    repeat (2) @(negedge conCLK);
    postCheck("runEarly", 9'd0, run);
    @(negedge conCLK);
    postCheck("runSet", 9'd1, run);
    @(posedge conCLK);
    #1;
    wbWrite(readSel, {5'b0, rowRunStart});
    wbRead(readSel, rd);
    postCheck("row4Run", 9'd1, rd);
    wbWrite(diagCtl, {5'b0, continueRun});
    @(posedge conCLK);
    #1;
    postCheck("startEarly", 9'd0, start);
    // This read is acknowledged on the edge that raises start
    wbRead(readSel, rd);
    postCheck("row4Pulse", 9'd3, rd);
    @(negedge conCLK);
    postCheck("startOneCycle", 9'd0, start);
    @(posedge conCLK);
    #1;
    wbWrite(diagCtl, {5'b0, clrRun});
    repeat (2) @(negedge conCLK);
    postCheck("runHeld", 9'd1, run);
    @(negedge conCLK);
    postCheck("runClr", 9'd0, run);
    @(posedge conCLK);
    #1;
    wbRead(readSel, rd);
    postCheck("row4Clr", 9'd0, rd);
    wbWrite(diagCtl, {5'b0, setRun});
    repeat (3) @(posedge conCLK);
    #1;
    runNow = 1'b1;

    // Special-instruction flags
    for (int i = 0; i < flagIters; i++) begin
      nextRand(r);
      cond  = `CON_COND_SPEC_INSTR;
      magic = r[8:0];
      flags = refFlags(r[8:0]);
      @(posedge conCLK);
      #1;
      postCheck("flagsLoad", flags[4:1], {eboxHalted, intDisable, pxct, pcPlus1Inh});
      cond  = quietCond(r[20:15]);
      magic = r[29:21];
      @(posedge conCLK);
      #1;
      postCheck("flagsHold", flags[4:1], {eboxHalted, intDisable, pxct, pcPlus1Inh});
    end
    cond = '0;
    wbWrite(readSel, {5'b0, rowFlags});
    wbRead(readSel, rd);
    postCheck("row2", flags, rd);

    // Microcode state bits
    for (int i = 0; i < stateIters; i++) begin
      nextRand(r);
      cond   = `CON_COND_EBOX_STATE;
      magic  = r[8:0];
      ustate = refState(ustate, r[8:0]);
      @(posedge conCLK);
      #1;
      postCheck("ucodeState", ustate, ucodeState);
    end
    cond = '0;

    // Skip selection, interrupt requests lead by one cycle
    prevPi  = 1'b0;
    prevMtr = 1'b0;
    for (int i = 0; i < skipIters; i++) begin
      nextRand(r);
      if (r[16]) begin
        c = {2'b11, r[20:17]};
      end else begin
        c = quietCond(r[22:17]);
      end
      cond = c;
      {vmaFetch, user, userIot, public, rdPseWr} = r[9:5];
      {piCycle, piXfer, ioLegalIr, vmaSection0, acRef} = r[4:0];
      piReady   = r[10];
      mtrIntReq = r[11];
      @(negedge conCLK);
      postCheck("skip", refSkip(c, r[9:0], prevPi, prevMtr, flags, runNow, 1'b0), skip);
      postCheck("loadIr", c == `CON_COND_LOAD_IR, loadIr);
      postCheck("kernelMode", !(r[8] || r[6]), kernelMode);
      prevPi  = r[10];
      prevMtr = r[11];
      @(posedge conCLK);
      #1;
    end

    // COND 14 raises loadIr in the same cycle
    cond = `CON_COND_LOAD_IR;
    @(negedge conCLK);
    postCheck("loadIrHigh", 9'd1, loadIr);
    postCheck("skipQuiet", 9'd0, skip);
    @(posedge conCLK);
    #1;
    cond = '0;

    #1;
    $display("checks %0d, errors %0d", nChecks, nErrors);
    if (nErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchNs);
    $display("run stopped by watchdog after %0d ns with %0d errors", watchNs, nErrors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/conUcodePkg.sv
verilog/conConsolePkg.sv
verilog/conIfs.sv
verilog/condDecoder.sv
verilog/dispatchSkip.sv
verilog/runControl.sv
verilog/specInstrState.sv
verilog/consoleRegs.sv
verilog/conTop.sv
testbench/con_properties.sv
testbench/conTb.sv

// File: Bender.yml
package:
  name: con_board

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/conUcodePkg.sv
      - verilog/conConsolePkg.sv
      - verilog/conIfs.sv
      - verilog/condDecoder.sv
      - verilog/dispatchSkip.sv
      - verilog/runControl.sv
      - verilog/specInstrState.sv
      - verilog/consoleRegs.sv
      - verilog/conTop.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - testbench/con_properties.sv
      - testbench/conTb.sv
